//--- verilog/cache_pkg.sv
package cache_pkg;

	// ========================================================================
	// Cache geometry
	// ========================================================================

	// Byte address width seen by the requester and the memory port
	localparam int ADDR_W = 32;
	// Four ways of 64 sets, each line sixteen bytes
	localparam int WAYS = 4;
	localparam int SETS = 64;
	localparam int LINE_BYTES = 16;

	// Address split into tag, set index and byte offset
	localparam int OFS_W = $clog2(LINE_BYTES);
	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = ADDR_W - IDX_W - OFS_W;
	localparam int WAY_W = $clog2(WAYS);

	// Replacement LFSR width and its nonzero reset value
	localparam int LFSR_W = 8;
	localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

	// ========================================================================
	// Field types
	// ========================================================================

	typedef logic [ADDR_W-1:0] address_t;
	// Upper address bits 31 down to 10
	typedef logic [TAG_W-1:0] tag_t;
	// Address bits 9 down to 4
	typedef logic [IDX_W-1:0] index_t;
	typedef logic [WAY_W-1:0] way_t;
	// Address with the byte offset dropped, as sent to memory
	typedef logic [ADDR_W-OFS_W-1:0] line_adr_t;
	// Word k of a line sits at bits 32k+31 down to 32k
	typedef logic [LINE_BYTES*8-1:0] line_t;
	typedef logic [31:0] word_t;

	// Lookup and refill sequence of the controller
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WAIT_MEM
	} ctrl_state_t;

endpackage

//--- verilog/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store
	import cache_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	// Set addressed by the current request
	input  index_t          rd_index,
	// Refill write port
	input  logic            fill,
	input  way_t            fill_way,
	input  index_t          fill_index,
	input  tag_t            fill_tag,
	// Clears every valid bit
	input  logic            flush,
	// Registered tags and valid bits of all ways of the addressed set
	output tag_t [WAYS-1:0] rd_tags,
	output logic [WAYS-1:0] rd_valid
);

	// Tag array, one entry per way and set
	tag_t tag_mem [WAYS][SETS];

	// Valid bits, one vector of sets per way
	logic [SETS-1:0] valid_q [WAYS];

	// ========================================================================
	// Tag array
	// ========================================================================

	// A refill writes the tag of one way while all ways are read every cycle
	// A read on the fill edge returns the old tag, which no lookup can see
	// because a new request is only sampled after the response
	always_ff @(posedge clk)
	begin
		if (fill)
			tag_mem[fill_way][fill_index] <= fill_tag;
		for (int w = 0; w < WAYS; w++)
			rd_tags[w] <= tag_mem[w][rd_index];
	end

	// ========================================================================
	// Valid bits
	// ========================================================================

	// Flush wins over a fill, although the protocol never lets both happen
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int w = 0; w < WAYS; w++)
				valid_q[w] <= '0;
		end
		else if (flush)
		begin
			for (int w = 0; w < WAYS; w++)
				valid_q[w] <= '0;
		end
		else if (fill)
			valid_q[fill_way][fill_index] <= 1'b1;
	end

	// Registered valid read, in step with the tag read
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_valid <= '0;
		else
			for (int w = 0; w < WAYS; w++)
				rd_valid[w] <= valid_q[w][rd_index];
	end

	// The controller only fills while a miss is pending and a flush may
	// only come while nothing is pending
	a_no_fill_during_flush: assert property (
		@(posedge clk) disable iff (!rst_n) !(fill && flush)
	) else $error("fill and flush in the same cycle");

endmodule

//--- verilog/cache_hit.sv
`timescale 1ns/1ps

module cache_hit
	import cache_pkg::*;
(
	// Tag of the pending request
	input  tag_t            tag,
	// Registered contents of the addressed set
	input  tag_t [WAYS-1:0] rd_tags,
	input  logic [WAYS-1:0] rd_valid,
	// Lookup result
	output logic            hit,
	output way_t            hit_way,
	// Set occupancy, used to choose a refill way
	output logic            set_full,
	output way_t            free_way
);

	// One bit per way that holds the requested tag
	logic [WAYS-1:0] way_hit;

	// ========================================================================
	// Tag compare
	// ========================================================================

	// A stored tag only counts when the way is valid
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
			way_hit[w] = rd_valid[w] && (rd_tags[w] == tag);
	end

	assign hit = |way_hit;

	// Encode the hitting way
	// With at most one way hitting the loop order does not matter
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++)
			if (way_hit[w])
				hit_way = way_t'(w);
	end

	// ========================================================================
	// Occupancy
	// ========================================================================

	assign set_full = &rd_valid;

	// Lowest numbered empty way, scanned from the top so the lowest wins
	// Only meaningful while the set is not full
	always_comb
	begin
		free_way = '0;
		for (int w = WAYS - 1; w >= 0; w--)
			if (!rd_valid[w])
				free_way = way_t'(w);
	end

	// A refill only happens after a miss on the same tag, so the tag store
	// can never hold one tag twice in a set
	always_comb
	begin
		a_one_way_hit: assert final ($onehot0(way_hit))
			else $error("more than one way hit");
	end

endmodule

//--- verilog/cache_replace.sv
`timescale 1ns/1ps

module cache_replace
	import cache_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	// One strobe per miss
	input  logic advance,
	// Occupancy of the set being refilled
	input  logic set_full,
	input  way_t free_way,
	// Way chosen for the refill
	output way_t victim
);

	// Fibonacci LFSR over x^8 + x^6 + x^5 + x^4 + 1
	logic [LFSR_W-1:0] lfsr_q;
	logic              lfsr_fb;

	assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

	// The sequence only moves on a miss
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			lfsr_q <= LFSR_SEED;
		else if (advance)
			lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_fb};
	end

	// An empty way is always taken first
	// Once the set is full the low LFSR bits pick a random way
	assign victim = set_full ? lfsr_q[WAY_W-1:0] : free_way;

	// The all zero state would lock up and leave way 0 as the only victim
	a_lfsr_nonzero: assert property (
		@(posedge clk) disable iff (!rst_n) lfsr_q != '0
	) else $error("replacement LFSR reached zero");

endmodule

//--- verilog/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store
	import cache_pkg::*;
(
	input  logic             clk,
	// Set addressed by the current request
	input  index_t           rd_index,
	// Refill write port
	input  logic             fill,
	input  way_t             fill_way,
	input  index_t           fill_index,
	input  line_t            fill_line,
	// Registered lines of all ways of the addressed set
	output line_t [WAYS-1:0] rd_lines
);

	// ========================================================================
	// Line array
	// ========================================================================

	// One full line per way and set
	line_t line_mem [WAYS][SETS];

	// Refill writes a whole line into the victim way
	always_ff @(posedge clk)
	begin
		if (fill)
			line_mem[fill_way][fill_index] <= fill_line;
	end

	// All four ways are read in parallel every cycle
	// The hit way is picked afterwards by the controller
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < WAYS; w++)
			rd_lines[w] <= line_mem[w][rd_index];
	end

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
	import cache_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	// Requester side
	input  logic             req,
	input  address_t         adr,
	// Lookup result
	input  logic             hit,
	input  way_t             hit_way,
	input  way_t             victim,
	input  line_t [WAYS-1:0] rd_lines,
	// Memory answer
	input  logic             mem_ack,
	input  line_t            mem_data,
	// Store read address and compare tag
	output index_t           rd_index,
	output tag_t             tag,
	// Refill into both stores
	output logic             fill,
	output way_t             fill_way,
	output index_t           fill_index,
	output tag_t             fill_tag,
	output line_t            fill_line,
	// Steps the replacement LFSR
	output logic             advance,
	// Response to the requester
	output logic             resp,
	output word_t            rdata,
	// Line request to memory
	output logic             mem_req,
	output line_adr_t        mem_adr
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	// Request address, held until the response
	address_t adr_q;
	// Way that the pending miss refills
	way_t victim_q;
	// Word inside the line
	logic [OFS_W-3:0] word_sel;
	// Lookup outcome in ST_LOOKUP
	logic lookup_hit;
	logic lookup_miss;

	// Pick one 32-bit word out of a line
	function automatic word_t pick_word(line_t line, logic [OFS_W-3:0] sel);
		return line[sel*$bits(word_t) +: $bits(word_t)];
	endfunction

	// ========================================================================
	// Address fields
	// ========================================================================

	// In the req cycle the index comes straight from the port so the stores
	// read the set on the edge that samples req
	assign rd_index = (state_q == ST_IDLE) ? adr[OFS_W+IDX_W-1:OFS_W]
		: adr_q[OFS_W+IDX_W-1:OFS_W];
	assign tag = adr_q[ADDR_W-1:ADDR_W-TAG_W];
	assign word_sel = adr_q[OFS_W-1:2];

	always_ff @(posedge clk)
	begin
		if (state_q == ST_IDLE && req)
			adr_q <= adr;
	end

	// ========================================================================
	// State machine
	// ========================================================================

	assign lookup_hit = (state_q == ST_LOOKUP) && hit;
	assign lookup_miss = (state_q == ST_LOOKUP) && !hit;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
				if (req)
					state_d = ST_LOOKUP;
			ST_LOOKUP:
				state_d = hit ? ST_IDLE : ST_WAIT_MEM;
			ST_WAIT_MEM:
				if (mem_ack)
					state_d = ST_IDLE;
			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// ========================================================================
	// Refill and memory request
	// ========================================================================

	// The victim is taken before the LFSR steps on the same edge
	always_ff @(posedge clk)
	begin
		if (lookup_miss)
		begin
			victim_q <= victim;
			mem_adr <= adr_q[ADDR_W-1:OFS_W];
		end
	end

	assign advance = lookup_miss;

	// Memory data goes into both stores on the edge that samples mem_ack
	assign fill = (state_q == ST_WAIT_MEM) && mem_ack;
	assign fill_way = victim_q;
	assign fill_index = adr_q[OFS_W+IDX_W-1:OFS_W];
	assign fill_tag = tag;
	assign fill_line = mem_data;

	// Response and memory request strobes, one cycle each
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			resp <= 1'b0;
			mem_req <= 1'b0;
		end
		else
		begin
			resp <= lookup_hit || fill;
			mem_req <= lookup_miss;
		end
	end

	// A refill answers from mem_data without a second lookup
	always_ff @(posedge clk)
	begin
		if (lookup_hit)
			rdata <= pick_word(rd_lines[hit_way], word_sel);
		else if (fill)
			rdata <= pick_word(mem_data, word_sel);
	end

	// Only one request may be outstanding
	a_req_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n) req |-> state_q == ST_IDLE
	) else $error("req while a request is pending");

	a_ack_when_waiting: assert property (
		@(posedge clk) disable iff (!rst_n) mem_ack |-> state_q == ST_WAIT_MEM
	) else $error("mem_ack without an outstanding mem_req");

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req,
	input  address_t  adr,
	input  logic      flush,
	input  logic      mem_ack,
	input  line_t     mem_data,
	output logic      resp,
	output word_t     rdata,
	output logic      mem_req,
	output line_adr_t mem_adr
);

	// Store read side
	index_t           rd_index;
	tag_t [WAYS-1:0]  rd_tags;
	logic [WAYS-1:0]  rd_valid;
	line_t [WAYS-1:0] rd_lines;

	// Lookup result and replacement
	tag_t             tag;
	logic             hit;
	way_t             hit_way;
	logic             set_full;
	way_t             free_way;
	way_t             victim;
	logic             advance;

	// Refill write side, shared by both stores
	logic             fill;
	way_t             fill_way;
	index_t           fill_index;
	tag_t             fill_tag;
	line_t            fill_line;

	cache_ctrl i_cache_ctrl (
		.clk(clk), .rst_n(rst_n), .req(req), .adr(adr),
		.hit(hit), .hit_way(hit_way), .victim(victim), .rd_lines(rd_lines),
		.mem_ack(mem_ack), .mem_data(mem_data), .rd_index(rd_index), .tag(tag),
		.fill(fill), .fill_way(fill_way), .fill_index(fill_index),
		.fill_tag(fill_tag), .fill_line(fill_line), .advance(advance),
		.resp(resp), .rdata(rdata), .mem_req(mem_req), .mem_adr(mem_adr)
	);

	// Flush only touches the valid bits
	cache_tag_store i_cache_tag_store (
		.clk(clk), .rst_n(rst_n), .rd_index(rd_index), .fill(fill),
		.fill_way(fill_way), .fill_index(fill_index), .fill_tag(fill_tag),
		.flush(flush), .rd_tags(rd_tags), .rd_valid(rd_valid)
	);

	cache_data_store i_cache_data_store (
		.clk(clk), .rd_index(rd_index), .fill(fill), .fill_way(fill_way),
		.fill_index(fill_index), .fill_line(fill_line), .rd_lines(rd_lines)
	);

	cache_hit i_cache_hit (
		.tag(tag), .rd_tags(rd_tags), .rd_valid(rd_valid), .hit(hit),
		.hit_way(hit_way), .set_full(set_full), .free_way(free_way)
	);

	cache_replace i_cache_replace (
		.clk(clk), .rst_n(rst_n), .advance(advance), .set_full(set_full),
		.free_way(free_way), .victim(victim)
	);

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
	import cache_pkg::*;
();

	logic      clk;
	logic      rst_n;
	logic      req;
	address_t  adr;
	logic      flush;
	logic      mem_ack;
	line_t     mem_data;
	logic      resp;
	word_t     rdata;
	logic      mem_req;
	line_adr_t mem_adr;

	// Pending request and what the scoreboard expects from its lookup
	address_t pend_adr;
	logic     exp_hit;
	logic     exp_miss;
	logic     seen_req;

	// Tags known to be resident in each set in fill order
	tag_t sb_tag [SETS][WAYS];
	int   sb_cnt [SETS];
	// Set once a set has seen a fifth tag and cleared again by a flush
	logic sb_unknown [SETS];

	int mismatch_cnt;
	int resp_cnt;
	int req_cnt;
	int cycle_cnt;

	icache_top i_icache_top (
		.clk(clk), .rst_n(rst_n), .req(req), .adr(adr), .flush(flush),
		.mem_ack(mem_ack), .mem_data(mem_data), .resp(resp), .rdata(rdata),
		.mem_req(mem_req), .mem_adr(mem_adr)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================================================
	// Memory pattern and model
	// ========================================================================

	// Scrambled word of the aligned byte address in which every address bit matters
	function automatic word_t pattern_word(address_t a);
		address_t w;
		w = {a[31:2], 2'b00};
		return (w * 32'h9E37_79B1) ^ {w[15:0], w[31:16]} ^ 32'h3C5A_96E1;
	endfunction

	function automatic line_t pattern_line(line_adr_t la);
		line_t line;
		for (int k = 0; k < 4; k++)
			line[k*32 +: 32] = pattern_word({la, k[1:0], 2'b00});
		return line;
	endfunction

	// Each mem_req gets exactly one mem_ack 1 to 8 cycles later
	initial
	begin : memory_model
		int        delay;
		line_adr_t la;
		mem_ack = 1'b0;
		mem_data = '0;
		forever
		begin
			@(negedge clk);
			if (mem_req)
			begin
				la = mem_adr;
				delay = $urandom_range(1, 8);
				repeat (delay) @(negedge clk);
				mem_ack = 1'b1;
				mem_data = pattern_line(la);
				@(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	// ========================================================================
	// Scoreboard and stimulus tasks
	// ========================================================================

	// Decide hit, miss or unknown for an address and record the refill
	task automatic classify(input address_t a);
		index_t s;
		tag_t   t;
		logic   found;
		s = a[OFS_W+IDX_W-1:OFS_W];
		t = a[ADDR_W-1:ADDR_W-TAG_W];
		found = 1'b0;
		for (int i = 0; i < sb_cnt[s]; i++)
			if (sb_tag[s][i] == t)
				found = 1'b1;
		exp_hit = !sb_unknown[s] && found;
		exp_miss = !sb_unknown[s] && !found;
		// A fifth tag may evict any way, so the set is no longer tracked
		if (exp_miss)
		begin
			if (sb_cnt[s] == WAYS)
				sb_unknown[s] = 1'b1;
			else
			begin
				sb_tag[s][sb_cnt[s]] = t;
				sb_cnt[s]++;
			end
		end
	endtask

	// Send one request and wait for its answer
	task automatic send_req(input address_t a);
		classify(a);
		pend_adr = a;
		seen_req = 1'b1;
		req_cnt++;
		req = 1'b1;
		adr = a;
		@(negedge clk);
		req = 1'b0;
		while (!resp)
			@(negedge clk);
		// One quiet cycle so the answer is checked against this address
		@(negedge clk);
	endtask

	task automatic do_flush();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		@(negedge clk);
		for (int s = 0; s < SETS; s++)
		begin
			sb_cnt[s] = 0;
			sb_unknown[s] = 1'b0;
		end
	endtask

	// Six tags over three sets, so sets fill up and evict
	function automatic address_t pool_adr();
		tag_t   t;
		index_t s;
		t = tag_t'($urandom_range(0, 5));
		s = index_t'($urandom_range(0, 2) * 7);
		return {t, s, 4'($urandom_range(0, 15))};
	endfunction

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial
	begin : stimulus
		void'($urandom(32'h5941ec39));
		rst_n = 1'b0;
		req = 1'b0;
		adr = '0;
		flush = 1'b0;
		pend_adr = '0;
		exp_hit = 1'b0;
		exp_miss = 1'b0;
		seen_req = 1'b0;
		mismatch_cnt = 0;
		resp_cnt = 0;
		req_cnt = 0;
		for (int s = 0; s < SETS; s++)
		begin
			sb_cnt[s] = 0;
			sb_unknown[s] = 1'b0;
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		// Idle cycles in which resp and mem_req must stay low
		repeat (4) @(negedge clk);

		// A miss followed by hits on other words of the same line
		send_req(32'h0000_1234);
		send_req(32'h0000_1238);
		send_req(32'h0000_1230);

		// Four tags into the empty set 5 and then all four hit
		for (int i = 1; i <= 4; i++)
			send_req({tag_t'(i * 3), index_t'(5), 4'h4});
		for (int i = 1; i <= 4; i++)
			send_req({tag_t'(i * 3), index_t'(5), 4'h8});
		send_req({tag_t'(99), index_t'(5), 4'h0});

		// Lines resident before a flush miss afterwards
		do_flush();
		send_req(32'h0000_1234);
		for (int i = 1; i <= 4; i++)
			send_req({tag_t'(i * 3), index_t'(5), 4'hC});

		// Random traffic with an occasional flush
		for (int n = 0; n < 300; n++)
		begin
			if ($urandom_range(0, 39) == 0)
				do_flush();
			send_req(pool_adr());
		end

		repeat (4) @(negedge clk);
		// Each request is answered exactly once
		assert (resp_cnt == req_cnt)
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: %0d responses for %0d requests", $time,
				resp_cnt, req_cnt);
		end
		$display("Closing counts: %0d mismatches, %0d responses, %0d requests",
			mismatch_cnt, resp_cnt, req_cnt);
		if (mismatch_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	always @(negedge clk)
	begin
		if (resp)
			resp_cnt++;
	end

	// About 15 cycles for each of some 320 requests leaves a wide margin
	initial
	begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < 20000)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run hung after %0d cycles with %0d mismatches",
			cycle_cnt, mismatch_cnt);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Every answer is the pattern word of the pending address
	a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		resp |-> rdata == pattern_word(pend_adr))
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: rdata %h for address %h, expected %h", $time,
			$sampled(rdata), pend_adr, pattern_word(pend_adr));
	end

	// Two cycles after req comes either the answer or the memory request
	a_one_answer: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> ##2 (resp != mem_req))
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: no single outcome 2 cycles after req to %h",
			$time, pend_adr);
	end

	a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
		req && exp_hit |-> ##2 (resp && !mem_req))
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: resident line %h did not hit", $time, pend_adr);
	end

	a_miss_timing: assert property (@(posedge clk) disable iff (!rst_n)
		req && exp_miss |-> ##2 (mem_req && !resp))
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: absent line %h did not miss", $time, pend_adr);
	end

	a_mem_adr: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req |-> mem_adr == pend_adr[ADDR_W-1:OFS_W])
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: mem_adr %h for address %h", $time,
			$sampled(mem_adr), pend_adr);
	end

	// The refill answers in the cycle after mem_ack
	a_fill_resp: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack |=> resp)
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: no resp one cycle after mem_ack", $time);
	end

	a_quiet_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_req |-> !resp && !mem_req)
	else
	begin
		mismatch_cnt++;
		$display("MISMATCH at %0t: resp or mem_req before the first req", $time);
	end

endmodule

//--- files.f
verilog/cache_pkg.sv
verilog/cache_tag_store.sv
verilog/cache_hit.sv
verilog/cache_replace.sv
verilog/cache_data_store.sv
verilog/cache_ctrl.sv
verilog/icache_top.sv
verif/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := icache_tb
FILELIST  := files.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The simulation counts as passed only if its output holds the pass message
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
